// ==== hw/inst_capture.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module inst_capture (
    input  wire logic                  in_clk,
    input  wire logic                  in_rst,
    input  wire logic                  in_valid_i,
    input  wire logic [`RV_INST_W-1:0] in_inst_i,
    output logic                       in_ready_o,
    output logic                       cap_valid_o,
    output logic [`RV_INST_W-1:0]      cap_inst_o,
    input  wire logic                  cap_ready_i
);

    logic                  valid_q;
    logic [`RV_INST_W-1:0] inst_q;
    logic                  load;

    // Room when empty or when the held word leaves this cycle
    assign in_ready_o = !valid_q || cap_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge in_clk or negedge in_rst) begin
        if (!in_rst) begin
            valid_q <= 1'b0;
            inst_q  <= '0;
        end else if (load) begin
            valid_q <= 1'b1;
            inst_q  <= in_inst_i;
        end else if (cap_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    assign cap_valid_o = valid_q;
    assign cap_inst_o  = inst_q;

endmodule

`default_nettype wire

// ==== hw/inst_classifier.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module inst_classifier
    import rv_decode_pkg::*;
(
    input  wire logic                  in_clk,
    input  wire logic                  in_rst,
    input  wire logic                  cap_valid_i,
    input  wire logic [`RV_INST_W-1:0] cap_inst_i,
    output logic                       cap_ready_o,
    output logic                       cls_valid_o,
    output rv_op_e                     cls_op_o,
    output rv_format_e                 cls_format_o,
    output logic [`RV_INST_W-1:0]      cls_inst_o,
    input  wire logic                  cls_ready_i
);

    rv_major_e             major;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [11:0]           imm12;
    logic                  rd_rs1_zero;
    rv_op_e                op;
    rv_format_e            fmt_major;
    rv_format_e            fmt;
    logic                  valid_q;
    rv_op_e                op_q;
    rv_format_e            fmt_q;
    logic [`RV_INST_W-1:0] inst_q;
    logic                  load;

    assign major  = rv_major_e'(cap_inst_i[`RV_MAJOR_W-1:0]);
    assign funct3 = cap_inst_i[14:12];
    assign funct7 = cap_inst_i[31:25];
    assign imm12  = cap_inst_i[31:20];
    // Fixed zero rd and rs1 for FENCE and SYSTEM specials
    assign rd_rs1_zero = (cap_inst_i[11:7] == '0) && (cap_inst_i[19:15] == '0);

    always_comb begin
        op = OP_ILLEGAL;
        case (major)
            MAJ_LUI:   op = OP_LUI;
            MAJ_AUIPC: op = OP_AUIPC;
            MAJ_JAL:   op = OP_JAL;
            MAJ_JALR: begin
                if (funct3 == 3'b000)
                    op = OP_JALR;
            end
            MAJ_BRANCH: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            MAJ_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            MAJ_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_ILLEGAL;
                endcase
            end
            MAJ_OP_IMM: begin
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    // Shifts keep funct7 in the upper immediate bits
                    3'b001: op = (funct7 == 7'b0000000) ? OP_SLLI : OP_ILLEGAL;
                    default: begin
                        if (funct7 == 7'b0000000)
                            op = OP_SRLI;
                        else if (funct7 == 7'b0100000)
                            op = OP_SRAI;
                    end
                endcase
            end
            MAJ_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_001: op = OP_SLL;
                    10'b0000000_010: op = OP_SLT;
                    10'b0000000_011: op = OP_SLTU;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_101: op = OP_SRL;
                    10'b0100000_101: op = OP_SRA;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_111: op = OP_AND;
                    default:         op = OP_ILLEGAL;
                endcase
            end
            MAJ_MISC_MEM: begin
                // pred and succ bits are free, fm must be zero
                if (rd_rs1_zero && funct3 == 3'b000 && cap_inst_i[31:28] == 4'b0000)
                    op = OP_FENCE;
                else if (rd_rs1_zero && funct3 == 3'b001 && imm12 == 12'h000)
                    op = OP_FENCE_I;
            end
            MAJ_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        if (rd_rs1_zero && imm12 == 12'h000)
                            op = OP_ECALL;
                        else if (rd_rs1_zero && imm12 == 12'h001)
                            op = OP_EBREAK;
                    end
                    3'b001:  op = OP_CSRRW;
                    3'b010:  op = OP_CSRRS;
                    3'b011:  op = OP_CSRRC;
                    3'b101:  op = OP_CSRRWI;
                    3'b110:  op = OP_CSRRSI;
                    3'b111:  op = OP_CSRRCI;
                    default: op = OP_ILLEGAL;
                endcase
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    // Format comes from the major opcode alone
    always_comb begin
        case (major)
            MAJ_LUI, MAJ_AUIPC: fmt_major = FMT_U;
            MAJ_JAL:            fmt_major = FMT_J;
            MAJ_BRANCH:         fmt_major = FMT_B;
            MAJ_STORE:          fmt_major = FMT_S;
            MAJ_OP:             fmt_major = FMT_R;
            default:            fmt_major = FMT_I;
        endcase
    end

    assign fmt = (op == OP_ILLEGAL) ? FMT_NONE : fmt_major;

    assign cap_ready_o = !valid_q || cls_ready_i;
    assign load        = cap_valid_i && cap_ready_o;

    always_ff @(posedge in_clk or negedge in_rst) begin
        if (!in_rst) begin
            valid_q <= 1'b0;
            op_q    <= OP_ILLEGAL;
            fmt_q   <= FMT_NONE;
            inst_q  <= '0;
        end else if (load) begin
            valid_q <= 1'b1;
            op_q    <= op;
            fmt_q   <= fmt;
            inst_q  <= cap_inst_i;
        end else if (cls_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    assign cls_valid_o  = valid_q;
    assign cls_op_o     = op_q;
    assign cls_format_o = fmt_q;
    assign cls_inst_o   = inst_q;

endmodule

`default_nettype wire

// ==== hw/operand_extract.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module operand_extract
    import rv_decode_pkg::*;
(
    input  wire logic                      in_clk,
    input  wire logic                      in_rst,
    input  wire logic                      cls_valid_i,
    input  wire rv_op_e                    cls_op_i,
    input  wire rv_format_e                cls_format_i,
    input  wire logic [`RV_INST_W-1:0]     cls_inst_i,
    output logic                           cls_ready_o,
    output logic                           out_valid_o,
    input  wire logic                      out_ready_i,
    output rv_op_e                         out_op_o,
    output rv_format_e                     out_format_o,
    output logic [`RV_REG_ADDR_W-1:0]      out_rd_o,
    output logic [`RV_REG_ADDR_W-1:0]      out_rs1_o,
    output logic [`RV_REG_ADDR_W-1:0]      out_rs2_o,
    output logic [`RV_INST_W-1:0]          out_imm_o
);

    logic [`RV_INST_W-1:0] w;
    logic [`RV_INST_W-1:0] imm;
    logic                  load;

    assign w = cls_inst_i;

    // Bit layout per format with the sign from bit 31
    always_comb begin
        case (cls_format_i)
            FMT_I:   imm = {{(`RV_INST_W-12){w[31]}}, w[31:20]};
            FMT_S:   imm = {{(`RV_INST_W-12){w[31]}}, w[31:25], w[11:7]};
            FMT_B:   imm = {{(`RV_INST_W-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   imm = {w[31:12], 12'b0};
            FMT_J:   imm = {{(`RV_INST_W-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign cls_ready_o = !out_valid_o || out_ready_i;
    assign load        = cls_valid_i && cls_ready_o;

    // Outputs hold while valid and not taken
    always_ff @(posedge in_clk or negedge in_rst) begin
        if (!in_rst) begin
            out_valid_o  <= 1'b0;
            out_op_o     <= OP_ILLEGAL;
            out_format_o <= FMT_NONE;
            out_rd_o     <= '0;
            out_rs1_o    <= '0;
            out_rs2_o    <= '0;
            out_imm_o    <= '0;
        end else if (load) begin
            out_valid_o  <= 1'b1;
            out_op_o     <= cls_op_i;
            out_format_o <= cls_format_i;
            out_rd_o     <= w[11:7];
            out_rs1_o    <= w[19:15];
            out_rs2_o    <= w[24:20];
            out_imm_o    <= imm;
        end else if (out_ready_i) begin
            out_valid_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_decode_config.svh ====
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// Instruction word and immediate width
`define RV_INST_W 32

// rd, rs1 and rs2 field width
`define RV_REG_ADDR_W 5

// Major opcode field, bits 6:0
`define RV_MAJOR_W 7

`endif

// ==== hw/rv_decode_pkg.sv ====
`default_nettype none
`include "rv_decode_config.svh"

package rv_decode_pkg;

    // RV32I major opcodes, bits 6:0 of the word
    typedef enum logic [`RV_MAJOR_W-1:0] {
        MAJ_LUI      = 7'b0110111,
        MAJ_AUIPC    = 7'b0010111,
        MAJ_JAL      = 7'b1101111,
        MAJ_JALR     = 7'b1100111,
        MAJ_BRANCH   = 7'b1100011,
        MAJ_LOAD     = 7'b0000011,
        MAJ_STORE    = 7'b0100011,
        MAJ_OP_IMM   = 7'b0010011,
        MAJ_OP       = 7'b0110011,
        MAJ_MISC_MEM = 7'b0001111,
        MAJ_SYSTEM   = 7'b1110011
    } rv_major_e;

    // Illegal sits at zero so a reset pipeline reads as empty
    typedef enum logic [5:0] {
        OP_ILLEGAL = 6'd0,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_FENCE, OP_FENCE_I,
        OP_ECALL, OP_EBREAK,
        OP_CSRRW, OP_CSRRS, OP_CSRRC,
        OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
    } rv_op_e;

    // Immediate layout classes
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } rv_format_e;

endpackage

`default_nettype wire

// ==== hw/rv_decoder_top.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module rv_decoder_top
    import rv_decode_pkg::*;
(
    input  wire logic                      in_clk,
    input  wire logic                      in_rst,
    input  wire logic                      in_valid_i,
    input  wire logic [`RV_INST_W-1:0]     in_inst_i,
    output logic                           in_ready_o,
    output logic                           out_valid_o,
    input  wire logic                      out_ready_i,
    output rv_op_e                         out_op_o,
    output rv_format_e                     out_format_o,
    output logic [`RV_REG_ADDR_W-1:0]      out_rd_o,
    output logic [`RV_REG_ADDR_W-1:0]      out_rs1_o,
    output logic [`RV_REG_ADDR_W-1:0]      out_rs2_o,
    output logic [`RV_INST_W-1:0]          out_imm_o
);

    logic                  cap_valid;
    logic [`RV_INST_W-1:0] cap_inst;
    logic                  cap_ready;
    logic                  cls_valid;
    rv_op_e                cls_op;
    rv_format_e            cls_format;
    logic [`RV_INST_W-1:0] cls_inst;
    logic                  cls_ready;

    inst_capture i_capture (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .in_valid_i  (in_valid_i),
        .in_inst_i   (in_inst_i),
        .in_ready_o  (in_ready_o),
        .cap_valid_o (cap_valid),
        .cap_inst_o  (cap_inst),
        .cap_ready_i (cap_ready)
    );

    inst_classifier i_classifier (
        .in_clk       (in_clk),
        .in_rst       (in_rst),
        .cap_valid_i  (cap_valid),
        .cap_inst_i   (cap_inst),
        .cap_ready_o  (cap_ready),
        .cls_valid_o  (cls_valid),
        .cls_op_o     (cls_op),
        .cls_format_o (cls_format),
        .cls_inst_o   (cls_inst),
        .cls_ready_i  (cls_ready)
    );

    // Ready runs back through all three stages in one cycle
    operand_extract i_extract (
        .in_clk       (in_clk),
        .in_rst       (in_rst),
        .cls_valid_i  (cls_valid),
        .cls_op_i     (cls_op),
        .cls_format_i (cls_format),
        .cls_inst_i   (cls_inst),
        .cls_ready_o  (cls_ready),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_op_o     (out_op_o),
        .out_format_o (out_format_o),
        .out_rd_o     (out_rd_o),
        .out_rs1_o    (out_rs1_o),
        .out_rs2_o    (out_rs2_o),
        .out_imm_o    (out_imm_o)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the decoder testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_decoder -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_decoder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+hw
+incdir+test
hw/rv_decode_pkg.sv
hw/inst_capture.sv
hw/inst_classifier.sv
hw/operand_extract.sv
hw/rv_decoder_top.sv
test/tb_rv_decoder.sv

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Match patterns from the RV32I opcode map, indexed by rv_op_e value
localparam logic [31:0] op_match_tbl [48] = '{
    32'h00000000, 32'h00000037, 32'h00000017, 32'h0000006f, 32'h00000067, 32'h00000063,
    32'h00001063, 32'h00004063, 32'h00005063, 32'h00006063, 32'h00007063, 32'h00000003,
    32'h00001003, 32'h00002003, 32'h00004003, 32'h00005003, 32'h00000023, 32'h00001023,
    32'h00002023, 32'h00000013, 32'h00002013, 32'h00003013, 32'h00004013, 32'h00006013,
    32'h00007013, 32'h00001013, 32'h00005013, 32'h40005013, 32'h00000033, 32'h40000033,
    32'h00001033, 32'h00002033, 32'h00003033, 32'h00004033, 32'h00005033, 32'h40005033,
    32'h00006033, 32'h00007033, 32'h0000000f, 32'h0000100f, 32'h00000073, 32'h00100073,
    32'h00001073, 32'h00002073, 32'h00003073, 32'h00005073, 32'h00006073, 32'h00007073
};

// Bits that an operation fixes, the rest are free fields
function automatic logic [31:0] fixed_mask(input int k);
    case (op_match_tbl[k][6:0])
        7'h37, 7'h17, 7'h6f: return 32'h0000007f;
        7'h33: return 32'hfe00707f;
        7'h13: return (op_match_tbl[k][13:12] == 2'b01) ? 32'hfe00707f : 32'h0000707f;
        7'h0f: return op_match_tbl[k][12] ? 32'hffffffff : 32'hf00fffff;
        7'h73: return (op_match_tbl[k][14:12] == 3'b000) ? 32'hffffffff : 32'h0000707f;
        default: return 32'h0000707f;
    endcase
endfunction

function automatic rv_op_e expect_op(input logic [31:0] w);
    for (int k = 1; k < 48; k++) begin
        if ((w & fixed_mask(k)) == op_match_tbl[k])
            return rv_op_e'(k);
    end
    return OP_ILLEGAL;
endfunction

function automatic rv_format_e expect_format(input logic [31:0] w);
    if (expect_op(w) == OP_ILLEGAL)
        return FMT_NONE;
    case (w[6:0])
        7'h37, 7'h17: return FMT_U;
        7'h6f: return FMT_J;
        7'h63: return FMT_B;
        7'h23: return FMT_S;
        7'h33: return FMT_R;
        default: return FMT_I;
    endcase
endfunction

function automatic logic [31:0] expect_imm(input logic [31:0] w);
    case (expect_format(w))
        FMT_I: return 32'($signed(w[31:20]));
        FMT_S: return 32'($signed({w[31:25], w[11:7]}));
        FMT_B: return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        FMT_U: return w & 32'hfffff000;
        FMT_J: return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        default: return 32'h0;
    endcase
endfunction

`endif

// ==== test/tb_rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_decode_config.svh"

module tb_rv_decoder
    import rv_decode_pkg::*;
();

    localparam int clk_half_ns = 4;
    localparam int reps_per_op = 4;
    localparam int n_random = 300;
    localparam int total_words = 47 * reps_per_op + 12 + n_random;
    localparam int watchdog_ns = (total_words * 20 + 8) * 2 * clk_half_ns;

    // Reserved encodings and nonzero fixed fields
    localparam logic [31:0] illegal_words [12] = '{
        32'h00000000, 32'h00002067, 32'h00002063, 32'h00003003, 32'h00003023, 32'h02000033,
        32'h40001013, 32'h0000108f, 32'h00008073, 32'h001000f3, 32'h00004073, 32'h8000000f
    };

    logic                      in_clk;
    logic                      in_rst;
    logic                      in_valid_i;
    logic [`RV_INST_W-1:0]     in_inst_i;
    logic                      in_ready_o;
    logic                      out_valid_o;
    logic                      out_ready_i;
    rv_op_e                    out_op_o;
    rv_format_e                out_format_o;
    logic [`RV_REG_ADDR_W-1:0] out_rd_o;
    logic [`RV_REG_ADDR_W-1:0] out_rs1_o;
    logic [`RV_REG_ADDR_W-1:0] out_rs2_o;
    logic [`RV_INST_W-1:0]     out_imm_o;

    integer                seed = 32'heacb;
    int                    mismatch_errs = 0;
    int                    protocol_errs = 0;
    int                    cycle = 0;
    bit                    random_mode = 1'b0;
    logic [`RV_INST_W-1:0] word_q[$];
    int                    accept_q[$];

    rv_decoder_top i_dut (.*);

    always #(clk_half_ns) in_clk = ~in_clk;

    `include "tb_ref_model.svh"

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            mismatch_errs++;
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    // Drive on the falling edge and see the accept at the rising edge
    task automatic step(input logic valid, input logic [31:0] w, output logic taken);
        @(negedge in_clk);
        in_valid_i = valid;
        in_inst_i = w;
        out_ready_i = random_mode ? 1'($random(seed)) : 1'b1;
        @(posedge in_clk);
        taken = valid && in_ready_o;
    endtask

    task automatic send_word(input logic [31:0] w);
        logic taken;
        taken = 1'b0;
        while (random_mode && ($random(seed) % 3 == 0))
            step(1'b0, '0, taken);
        while (!taken)
            step(1'b1, w, taken);
    endtask

    always @(posedge in_clk) begin : scoreboard
        logic [31:0] w;
        int t;
        if (in_rst) begin
            if (in_valid_i && in_ready_o) begin
                word_q.push_back(in_inst_i);
                accept_q.push_back(cycle);
            end
            if (out_valid_o && out_ready_i) begin
                assert (word_q.size() > 0) else begin
                    protocol_errs++;
                    $display("Output transfer with no accepted word left");
                end
                if (word_q.size() > 0) begin
                    w = word_q.pop_front();
                    t = accept_q.pop_front();
                    check_field("out_op_o", 32'(expect_op(w)), 32'(out_op_o));
                    check_field("out_format_o", 32'(expect_format(w)), 32'(out_format_o));
                    check_field("out_rd_o", 32'(w[11:7]), 32'(out_rd_o));
                    check_field("out_rs1_o", 32'(w[19:15]), 32'(out_rs1_o));
                    check_field("out_rs2_o", 32'(w[24:20]), 32'(out_rs2_o));
                    check_field("out_imm_o", expect_imm(w), out_imm_o);
                    // Three registers deep when never stalled
                    if (!random_mode) begin
                        assert (cycle - t == 3) else begin
                            protocol_errs++;
                            $display("Word came out after %0d cycles instead of 3", cycle - t);
                        end
                    end
                end
            end
            cycle++;
        end
    end

    hold_under_stall: assert property (@(posedge in_clk) disable iff (!in_rst)
        out_valid_o && !out_ready_i |=> out_valid_o &&
        $stable({out_op_o, out_format_o, out_rd_o, out_rs1_o, out_rs2_o, out_imm_o}))
    else begin
        protocol_errs++;
        $display("Outputs changed while held by back-pressure");
    end

    accept_every_cycle: assert property (@(posedge in_clk) disable iff (!in_rst)
        !random_mode && in_valid_i |-> in_ready_o)
    else begin
        protocol_errs++;
        $display("Input stalled although the output was always ready");
    end

    initial begin : stimulus
        logic taken;
        int k;
        in_clk = 1'b0;
        in_rst = 1'b0;
        in_valid_i = 1'b0;
        in_inst_i = '0;
        out_ready_i = 1'b0;
        repeat (8) @(posedge in_clk);
        @(negedge in_clk);
        in_rst = 1'b1;
        assert (!out_valid_o && in_ready_o) else begin
            protocol_errs++;
            $display("Pipeline not empty after reset");
        end
        // Every operation back to back with random free fields
        for (int op = 1; op < 48; op++) begin
            repeat (reps_per_op)
                send_word(($random(seed) & ~fixed_mask(op)) | op_match_tbl[op]);
        end
        foreach (illegal_words[i])
            send_word(illegal_words[i]);
        @(negedge in_clk);
        in_valid_i = 1'b0;
        random_mode = 1'b1;
        for (int n = 0; n < n_random; n++) begin
            k = 1 + ({$random(seed)} % 47);
            if ($random(seed) % 2 == 0)
                send_word($random(seed));
            else
                send_word(($random(seed) & ~fixed_mask(k)) | op_match_tbl[k]);
        end
        // Last accepted word is in the queue by the falling edge
        @(negedge in_clk);
        in_valid_i = 1'b0;
        while (word_q.size() > 0)
            step(1'b0, '0, taken);
        $display("Checks done: %0d mismatch errors, %0d protocol errors",
                 mismatch_errs, protocol_errs);
        if (mismatch_errs + protocol_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: run did not finish within %0d ns", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
